//--- turfio_cmd_path.f
+incdir+tests
design/turfio_cmd_pkg.sv
design/turfio_cmd_decoder.sv
design/trig_time_fifo.sv
design/trig_out_stage.sv
design/turfio_cmd_path.sv
tests/turfio_cmd_path_tb.sv

//--- Bender.yml
package:
  name: turfio_cmd_path

sources:
  # RTL in compile order
  - design/turfio_cmd_pkg.sv
  - design/turfio_cmd_decoder.sv
  - design/trig_time_fifo.sv
  - design/trig_out_stage.sv
  - design/turfio_cmd_path.sv
  # Testbench
  - target: test
    include_dirs:
      - tests
    files:
      - tests/turfio_cmd_path_tb.sv

//--- tests/turfio_cmd_path_vectors.svh
// Columns: test number, command word, valid, ready mode, idle cycles after the row
// Word low nibble is bit 3 trigger, bit 2 PPS, bits 1:0 run command; time sits at bits 18:4

// Ready modes
localparam logic [1:0] RDY_LOW  = 2'd0;
localparam logic [1:0] RDY_HIGH = 2'd1;
localparam logic [1:0] RDY_RAND = 2'd2;

typedef struct packed {
    logic [2:0]       test;
    logic [CMD_W-1:0] cmd;
    logic             valid;
    logic [1:0]       ready;
    logic [7:0]       idle;
} vec_row_t;

localparam int NUM_ROWS = 42;

string test_name [1:6] = '{
    "reset state", "run-control pulses", "trigger order",
    "credit exhaustion", "reset numbering", "stop flush"
};

vec_row_t vectors [NUM_ROWS] = '{
    // Sync, reset, stop, PPS, then sync with PPS back to back with an ignored word
    '{3'd2, 32'h0000_0001, 1'b1, RDY_HIGH, 8'd2},
    '{3'd2, 32'h0000_0002, 1'b1, RDY_HIGH, 8'd2},
    '{3'd2, 32'h0000_0003, 1'b1, RDY_HIGH, 8'd2},
    '{3'd2, 32'h0000_0004, 1'b1, RDY_HIGH, 8'd2},
    '{3'd2, 32'h0000_0005, 1'b1, RDY_HIGH, 8'd0},
    '{3'd2, 32'h0000_0fff, 1'b0, RDY_HIGH, 8'd3},
    // Burst under random ready, junk above bit 18 in one word
    '{3'd3, 32'h0000_1238, 1'b1, RDY_RAND, 8'd1},
    '{3'd3, 32'h0000_4568, 1'b1, RDY_RAND, 8'd0},
    '{3'd3, 32'h5a07_fff8, 1'b1, RDY_RAND, 8'd1},
    '{3'd3, 32'h0000_0008, 1'b1, RDY_RAND, 8'd2},
    '{3'd3, 32'h0007_ffec, 1'b1, RDY_RAND, 8'd1},
    '{3'd3, 32'h0000_0000, 1'b0, RDY_HIGH, 8'd16},
    // Ten triggers into a stalled output, the last one has no credit
    '{3'd4, 32'h0000_1018, 1'b1, RDY_LOW, 8'd1},
    '{3'd4, 32'h0000_1028, 1'b1, RDY_LOW, 8'd1},
    '{3'd4, 32'h0000_1038, 1'b1, RDY_LOW, 8'd1},
    '{3'd4, 32'h0000_1048, 1'b1, RDY_LOW, 8'd1},
    '{3'd4, 32'h0000_1058, 1'b1, RDY_LOW, 8'd1},
    '{3'd4, 32'h0000_1068, 1'b1, RDY_LOW, 8'd1},
    '{3'd4, 32'h0000_1078, 1'b1, RDY_LOW, 8'd1},
    '{3'd4, 32'h0000_1088, 1'b1, RDY_LOW, 8'd1},
    '{3'd4, 32'h0000_1098, 1'b1, RDY_LOW, 8'd1},
    '{3'd4, 32'h0000_10a8, 1'b1, RDY_LOW, 8'd1},
    '{3'd4, 32'h0000_0000, 1'b0, RDY_HIGH, 8'd20},
    // Reset word with its own trigger, then a bare reset word
    '{3'd5, 32'h0000_0aaa, 1'b1, RDY_HIGH, 8'd5},
    '{3'd5, 32'h0000_0bb8, 1'b1, RDY_HIGH, 8'd5},
    '{3'd5, 32'h0000_0002, 1'b1, RDY_HIGH, 8'd2},
    '{3'd5, 32'h0000_0cc8, 1'b1, RDY_HIGH, 8'd6},
    // Three queued, stop with trigger bit set, then refill to full depth
    '{3'd6, 32'h0000_2018, 1'b1, RDY_LOW, 8'd2},
    '{3'd6, 32'h0000_2028, 1'b1, RDY_LOW, 8'd2},
    '{3'd6, 32'h0000_2038, 1'b1, RDY_LOW, 8'd2},
    '{3'd6, 32'h0000_204b, 1'b1, RDY_LOW, 8'd5},
    '{3'd6, 32'h0000_0000, 1'b0, RDY_HIGH, 8'd12},
    '{3'd6, 32'h0000_3018, 1'b1, RDY_LOW, 8'd1},
    '{3'd6, 32'h0000_3028, 1'b1, RDY_LOW, 8'd1},
    '{3'd6, 32'h0000_3038, 1'b1, RDY_LOW, 8'd1},
    '{3'd6, 32'h0000_3048, 1'b1, RDY_LOW, 8'd1},
    '{3'd6, 32'h0000_3058, 1'b1, RDY_LOW, 8'd1},
    '{3'd6, 32'h0000_3068, 1'b1, RDY_LOW, 8'd1},
    '{3'd6, 32'h0000_3078, 1'b1, RDY_LOW, 8'd1},
    '{3'd6, 32'h0000_3088, 1'b1, RDY_LOW, 8'd1},
    '{3'd6, 32'h0000_3098, 1'b1, RDY_LOW, 8'd1},
    '{3'd6, 32'h0000_0000, 1'b0, RDY_HIGH, 8'd20}
};

//--- tests/turfio_cmd_path_tb.sv
`timescale 1ns/10ps
`default_nettype none

module turfio_cmd_path_tb;
    import turfio_cmd_pkg::*;

    `include "turfio_cmd_path_vectors.svh"

    // DUT ports
    logic                  init_clk;
    logic                  reset_i;
    logic [CMD_W-1:0]      command_i;
    logic                  command_valid_i;
    logic                  trig_ready_i;
    run_ctl_t              run_ctl_o;
    trig_entry_t           trig_o;
    logic                  trig_valid_o;
    logic [DROP_W-1:0]     drop_count_o;

    // Reference model
    trig_entry_t           exp_q [$];
    trig_entry_t           head_exp;
    logic [TRIG_SEQ_W-1:0] exp_seq;
    logic [DROP_W-1:0]     exp_drops;
    run_ctl_t              exp_ctl_q;

    // Stall tracking
    logic                  stall_q;
    trig_entry_t           held_q;

    // Counts and run limit
    int                    errors;
    int                    test_base;
    int                    tests_passed;
    int                    tests_failed;
    int                    cycle_count;
    int                    cycle_limit;

    always #10 init_clk = ~init_clk;

    turfio_cmd_path uut (
        .init_clk        (init_clk),
        .reset_i         (reset_i),
        .command_i       (command_i),
        .command_valid_i (command_valid_i),
        .run_ctl_o       (run_ctl_o),
        .trig_o          (trig_o),
        .trig_valid_o    (trig_valid_o),
        .trig_ready_i    (trig_ready_i),
        .drop_count_o    (drop_count_o)
    );

    //////////////////////////////////////////////////
    // Model helpers
    //////////////////////////////////////////////////

    // Pulses a word raises one cycle after it is sampled
    function automatic run_ctl_t expected_ctl(input logic [CMD_W-1:0] word, input logic valid);
        run_ctl_t ctl;
        ctl = '0;
        if (valid) begin
            ctl.sync  = (word[RUNCMD_LSB +: RUNCMD_W] == RUNCMD_SYNC);
            ctl.reset = (word[RUNCMD_LSB +: RUNCMD_W] == RUNCMD_RESET);
            ctl.stop  = (word[RUNCMD_LSB +: RUNCMD_W] == RUNCMD_STOP);
            ctl.pps   = word[PPS_BIT];
        end
        return ctl;
    endfunction

    // Head entry sits in the output register, its credit already back
    function automatic int free_credits();
        if (exp_q.size() == 0) begin
            return TRIG_DEPTH;
        end
        return TRIG_DEPTH - (exp_q.size() - 1);
    endfunction

    task automatic flag_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        $display("[ERROR] %0d ns: %s expected 0x%0h, got 0x%0h", $time, name, expected, actual);
        errors++;
    endtask

    task automatic drive_ready(input logic [1:0] mode);
        logic [31:0] rnd;
        if (mode == RDY_RAND) begin
            rnd = $urandom;
            trig_ready_i = rnd[0];
        end else begin
            trig_ready_i = (mode == RDY_HIGH);
        end
    endtask

    //////////////////////////////////////////////////
    // Row driver and test wrap-up
    //////////////////////////////////////////////////

    // Drive a row just after the edge, update the model, then idle
    task automatic apply_row(input vec_row_t row);
        logic [RUNCMD_W-1:0] runcmd;
        trig_entry_t         entry;
        @(posedge init_clk);
        #2;
        command_i       = row.cmd;
        command_valid_i = row.valid;
        drive_ready(row.ready);
        runcmd = row.cmd[RUNCMD_LSB +: RUNCMD_W];
        if (row.valid) begin
            if (runcmd == RUNCMD_RESET) begin
                exp_seq = '0;
            end
            if (runcmd == RUNCMD_STOP) begin
                // Flush discards everything queued, trigger bit ignored
                exp_q.delete();
            end else if (row.cmd[TRIG_BIT]) begin
                if (free_credits() > 0) begin
                    entry.seq       = exp_seq;
                    entry.trig_time = row.cmd[TRIG_TIME_LSB +: TRIG_TIME_W];
                    exp_q.push_back(entry);
                    exp_seq = exp_seq + 1'b1;
                end else if (exp_drops != '1) begin
                    exp_drops = exp_drops + 1'b1;
                end
            end
        end
        repeat (row.idle) begin
            @(posedge init_clk);
            #2;
            command_i       = '0;
            command_valid_i = 1'b0;
            drive_ready(row.ready);
        end
    endtask

    // Past the monitor's negedge so the queue is settled
    task automatic finish_test(input int num);
        @(negedge init_clk);
        #1;
        if (drop_count_o !== exp_drops) begin
            flag_mismatch("drop_count_o", exp_drops, drop_count_o);
        end
        if (exp_q.size() != 0) begin
            $display("Test %0d: %0d expected triggers never came out", num, exp_q.size());
            errors++;
        end
        if (errors == test_base) begin
            tests_passed++;
            $display("Test %0d %s: PASS", num, test_name[num]);
        end else begin
            tests_failed++;
            $display("Test %0d %s: FAIL, %0d errors", num, test_name[num], errors - test_base);
        end
        test_base = errors;
    endtask

    //////////////////////////////////////////////////
    // Output monitor, sampled mid-cycle
    //////////////////////////////////////////////////

    always @(negedge init_clk) begin
        if (reset_i) begin
            stall_q = 1'b0;
        end else begin
            if (run_ctl_o !== exp_ctl_q) begin
                flag_mismatch("run_ctl_o", exp_ctl_q, run_ctl_o);
            end
            // Held entry must not move under back-pressure
            if (stall_q && trig_valid_o && trig_o !== held_q) begin
                flag_mismatch("trig_o while stalled", held_q, trig_o);
            end
            // Transfer happens on the coming edge
            if (trig_valid_o && trig_ready_i) begin
                if (exp_q.size() == 0) begin
                    $display("Trigger seq %0d delivered at %0d ns with nothing expected",
                             trig_o.seq, $time);
                    errors++;
                end else begin
                    head_exp = exp_q.pop_front();
                    if (trig_o.seq !== head_exp.seq) begin
                        flag_mismatch("trig_o.seq", head_exp.seq, trig_o.seq);
                    end
                    if (trig_o.trig_time !== head_exp.trig_time) begin
                        flag_mismatch("trig_o.trig_time", head_exp.trig_time, trig_o.trig_time);
                    end
                end
            end
            stall_q = trig_valid_o && !trig_ready_i;
            held_q  = trig_o;
        end
        exp_ctl_q = expected_ctl(command_i, command_valid_i);
    end

    // Run bound
    always @(posedge init_clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("Timeout: run went past its limit of %0d cycles", cycle_limit);
            $display("Simulation failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    initial begin
        void'($urandom(32'hc001_807d));
        init_clk        = 1'b0;
        reset_i         = 1'b1;
        command_i       = '0;
        command_valid_i = 1'b0;
        trig_ready_i    = 1'b0;
        exp_seq         = '0;
        exp_drops       = '0;
        exp_ctl_q       = '0;
        stall_q         = 1'b0;
        held_q          = '0;
        errors          = 0;
        test_base       = 0;
        tests_passed    = 0;
        tests_failed    = 0;
        cycle_count     = 0;
        // Twice the table length plus margin
        cycle_limit = 200;
        foreach (vectors[r]) begin
            cycle_limit += 2 * (1 + vectors[r].idle);
        end

        repeat (16) @(posedge init_clk);
        #2;
        reset_i = 1'b0;

        // Reset state
        @(negedge init_clk);
        #1;
        if (run_ctl_o !== '0) begin
            flag_mismatch("run_ctl_o", 0, run_ctl_o);
        end
        if (trig_valid_o !== 1'b0) begin
            flag_mismatch("trig_valid_o", 0, trig_valid_o);
        end
        finish_test(1);

        for (int r = 0; r < NUM_ROWS; r++) begin
            apply_row(vectors[r]);
            if (r == NUM_ROWS - 1 || vectors[r + 1].test != vectors[r].test) begin
                finish_test(vectors[r].test);
            end
        end

        $display("Tests passed: %0d, failed: %0d, errors: %0d",
                 tests_passed, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- design/turfio_cmd_path.sv
`timescale 1ns/10ps
`default_nettype none

module turfio_cmd_path (
    input  wire                                init_clk,
    input  wire                                reset_i,
    // TURF command words
    input  wire [turfio_cmd_pkg::CMD_W-1:0]    command_i,
    input  wire                                command_valid_i,
    // Run control pulses
    output turfio_cmd_pkg::run_ctl_t           run_ctl_o,
    // Trigger delivery
    output turfio_cmd_pkg::trig_entry_t        trig_o,
    output logic                               trig_valid_o,
    input  wire                                trig_ready_i,
    // Triggers lost for lack of credit
    output logic [turfio_cmd_pkg::DROP_W-1:0]  drop_count_o
);
    import turfio_cmd_pkg::*;

    // Decoder to FIFO
    logic        push;
    trig_entry_t push_entry;
    logic        credit_return;

    // FIFO to output stage
    trig_entry_t fifo_head;
    logic        fifo_not_empty;
    logic        pop;

    //////////////////////////////////////////////////
    // Command decode, producer side
    //////////////////////////////////////////////////

    turfio_cmd_decoder u_decoder (
        .init_clk        (init_clk),
        .reset_i         (reset_i),
        .command_i       (command_i),
        .command_valid_i (command_valid_i),
        .credit_return_i (credit_return),
        .push_o          (push),
        .entry_o         (push_entry),
        .run_ctl_o       (run_ctl_o),
        .drop_count_o    (drop_count_o)
    );

    // Trigger queue
    trig_time_fifo u_fifo (
        .init_clk        (init_clk),
        .reset_i         (reset_i),
        .push_i          (push),
        .entry_i         (push_entry),
        .pop_i           (pop),
        .head_o          (fifo_head),
        .not_empty_o     (fifo_not_empty),
        .credit_return_o (credit_return)
    );

    // Delivery, flushed by the stop pulse
    trig_out_stage u_out (
        .init_clk     (init_clk),
        .reset_i      (reset_i),
        .head_i       (fifo_head),
        .not_empty_i  (fifo_not_empty),
        .pop_o        (pop),
        .run_stop_i   (run_ctl_o.stop),
        .trig_o       (trig_o),
        .trig_valid_o (trig_valid_o),
        .trig_ready_i (trig_ready_i)
    );

endmodule

`default_nettype wire

//--- design/trig_out_stage.sv
`timescale 1ns/10ps
`default_nettype none

module trig_out_stage (
    input  wire                              init_clk,
    input  wire                              reset_i,
    // FIFO head and its pop strobe
    input  wire turfio_cmd_pkg::trig_entry_t head_i,
    input  wire                              not_empty_i,
    output logic                             pop_o,
    // Stop pulse from the decoder
    input  wire                              run_stop_i,
    // Outgoing trigger with valid/ready
    output turfio_cmd_pkg::trig_entry_t      trig_o,
    output logic                             trig_valid_o,
    input  wire                              trig_ready_i
);

    // Normal delivery or draining after a stop
    typedef enum logic {
        ST_RUN   = 1'b0,
        ST_FLUSH = 1'b1
    } state_t;

    state_t state_q;

    // Handshake terms
    logic   take;
    logic   flushing;
    logic   load;

    // Transfer to the outside this cycle
    assign take = trig_valid_o && trig_ready_i;

    // Stop acts in its own cycle as well
    assign flushing = (state_q == ST_FLUSH) || run_stop_i;

    // Refill when empty or being emptied
    assign load = !flushing && not_empty_i && (!trig_valid_o || trig_ready_i);

    // Drain everything while flushing
    assign pop_o = flushing ? not_empty_i : load;

    //////////////////////////////////////////////////
    // Valid and flush state
    //////////////////////////////////////////////////

    always_ff @(posedge init_clk) begin
        if (reset_i) begin
            state_q      <= ST_RUN;
            trig_valid_o <= 1'b0;
        end else if (flushing) begin
            // Held entry is thrown away
            trig_valid_o <= 1'b0;
            // Back to normal once the FIFO reads empty
            if (not_empty_i) begin
                state_q <= ST_FLUSH;
            end else begin
                state_q <= ST_RUN;
            end
        end else if (load) begin
            trig_valid_o <= 1'b1;
        end else if (take) begin
            trig_valid_o <= 1'b0;
        end
    end

    //////////////////////////////////////////////////
    // Output register
    //////////////////////////////////////////////////

    // Only changes on load, so stable while stalled
    always_ff @(posedge init_clk) begin
        if (load) begin
            trig_o <= head_i;
        end
    end

endmodule

`default_nettype wire

//--- design/trig_time_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module trig_time_fifo (
    input  wire                          init_clk,
    input  wire                          reset_i,
    // Write side, never pushed when full
    input  wire                          push_i,
    input  wire turfio_cmd_pkg::trig_entry_t entry_i,
    // Read side
    input  wire                          pop_i,
    output turfio_cmd_pkg::trig_entry_t  head_o,
    output logic                         not_empty_o,
    // Registered echo of each pop
    output logic                         credit_return_o
);
    import turfio_cmd_pkg::*;

    // Entry storage
    trig_entry_t           mem [TRIG_DEPTH];

    // Pointers and fill level
    logic [FIFO_PTR_W-1:0] wr_ptr_q;
    logic [FIFO_PTR_W-1:0] rd_ptr_q;
    logic [CREDIT_W-1:0]   count_q;

    // Pop only counts when something is there
    logic                  pop_ok;

    assign not_empty_o = (count_q != '0);
    assign pop_ok      = pop_i && not_empty_o;

    // Head is read straight from storage
    assign head_o = mem[rd_ptr_q];

    //////////////////////////////////////////////////
    // Storage write
    //////////////////////////////////////////////////

    always_ff @(posedge init_clk) begin
        if (push_i) begin
            mem[wr_ptr_q] <= entry_i;
        end
    end

    //////////////////////////////////////////////////
    // Pointers, count, credit return
    //////////////////////////////////////////////////

    always_ff @(posedge init_clk) begin
        if (reset_i) begin
            wr_ptr_q        <= '0;
            rd_ptr_q        <= '0;
            count_q         <= '0;
            credit_return_o <= 1'b0;
        end else begin
            // Write pointer wraps at the last slot
            if (push_i) begin
                if (wr_ptr_q == FIFO_PTR_W'(TRIG_DEPTH - 1)) begin
                    wr_ptr_q <= '0;
                end else begin
                    wr_ptr_q <= wr_ptr_q + 1'b1;
                end
            end

            // Same for the read pointer
            if (pop_ok) begin
                if (rd_ptr_q == FIFO_PTR_W'(TRIG_DEPTH - 1)) begin
                    rd_ptr_q <= '0;
                end else begin
                    rd_ptr_q <= rd_ptr_q + 1'b1;
                end
            end

            // Fill level
            count_q <= count_q + CREDIT_W'(push_i) - CREDIT_W'(pop_ok);

            // One credit back per removed entry, next cycle
            credit_return_o <= pop_ok;
        end
    end

endmodule

`default_nettype wire

//--- design/turfio_cmd_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module turfio_cmd_decoder (
    input  wire                                init_clk,
    input  wire                                reset_i,
    // Command words, no back-pressure
    input  wire [turfio_cmd_pkg::CMD_W-1:0]    command_i,
    input  wire                                command_valid_i,
    // One pulse per entry leaving the FIFO
    input  wire                                credit_return_i,
    // Push side of the trigger FIFO
    output logic                               push_o,
    output turfio_cmd_pkg::trig_entry_t        entry_o,
    // Decoded run controls
    output turfio_cmd_pkg::run_ctl_t           run_ctl_o,
    output logic [turfio_cmd_pkg::DROP_W-1:0]  drop_count_o
);
    import turfio_cmd_pkg::*;

    // Fields of the incoming word
    logic [RUNCMD_W-1:0]    runcmd;
    logic [TRIG_TIME_W-1:0] trig_time;

    // Trigger bookkeeping
    logic                   trig_req;
    logic                   have_credit;
    logic                   accept;
    logic                   drop;
    logic                   seq_clear;
    logic [TRIG_SEQ_W-1:0]  seq_q;
    logic [TRIG_SEQ_W-1:0]  seq_base;
    logic [CREDIT_W-1:0]    credits_q;

    // Next value of the run control pulses
    run_ctl_t               run_ctl_d;

    assign runcmd    = command_i[RUNCMD_LSB +: RUNCMD_W];
    assign trig_time = command_i[TRIG_TIME_LSB +: TRIG_TIME_W];

    //////////////////////////////////////////////////
    // Run command decode
    //////////////////////////////////////////////////

    always_comb begin
        run_ctl_d = '0;
        if (command_valid_i) begin
            case (runcmd)
                RUNCMD_SYNC:  run_ctl_d.sync = 1'b1;
                RUNCMD_RESET: run_ctl_d.reset = 1'b1;
                RUNCMD_STOP:  run_ctl_d.stop = 1'b1;
                // Plain word, no run action
                RUNCMD_NONE:  ;
            endcase
            // PPS rides along with any run command
            run_ctl_d.pps = command_i[PPS_BIT];
        end
    end

    //////////////////////////////////////////////////
    // Trigger accept or drop
    //////////////////////////////////////////////////

    // Trigger bit in a stop word is not a trigger
    assign trig_req = command_valid_i && command_i[TRIG_BIT] && (runcmd != RUNCMD_STOP);

    // Credits left means the FIFO has a free slot
    assign have_credit = (credits_q != '0);
    assign accept      = trig_req && have_credit;
    assign drop        = trig_req && !have_credit;

    // Reset word restarts numbering, its own trigger included
    assign seq_clear = run_ctl_d.reset;
    assign seq_base  = seq_clear ? '0 : seq_q;

    // Control state
    always_ff @(posedge init_clk) begin
        if (reset_i) begin
            run_ctl_o    <= '0;
            push_o       <= 1'b0;
            seq_q        <= '0;
            credits_q    <= CREDIT_W'(TRIG_DEPTH);
            drop_count_o <= '0;
        end else begin
            run_ctl_o <= run_ctl_d;
            push_o    <= accept;

            // Only accepted triggers advance the number
            if (accept) begin
                seq_q <= seq_base + 1'b1;
            end else if (seq_clear) begin
                seq_q <= '0;
            end

            // Push and return may land together
            credits_q <= credits_q - CREDIT_W'(accept) + CREDIT_W'(credit_return_i);

            // Saturate at all ones
            if (drop && !(&drop_count_o)) begin
                drop_count_o <= drop_count_o + 1'b1;
            end
        end
    end

    // Entry presented with push_o
    always_ff @(posedge init_clk) begin
        if (accept) begin
            entry_o.seq       <= seq_base;
            entry_o.trig_time <= trig_time;
        end
    end

endmodule

`default_nettype wire

//--- design/turfio_cmd_pkg.sv
`default_nettype none

package turfio_cmd_pkg;

    //////////////////////////////////////////////////
    // Widths and depth
    //////////////////////////////////////////////////

    // One TURF command word
    localparam int CMD_W = 32;
    // Trigger time carried in the command word
    localparam int TRIG_TIME_W = 15;
    // Running trigger number
    localparam int TRIG_SEQ_W = 16;
    // Trigger FIFO entries, also the credits held after reset
    localparam int TRIG_DEPTH = 8;
    // Must reach TRIG_DEPTH itself
    localparam int CREDIT_W = $clog2(TRIG_DEPTH + 1);
    // FIFO read/write pointer width
    localparam int FIFO_PTR_W = $clog2(TRIG_DEPTH);
    // Saturating drop counter
    localparam int DROP_W = 16;

    //////////////////////////////////////////////////
    // Command word layout
    //////////////////////////////////////////////////

    // Run command field
    localparam int RUNCMD_W = 2;
    localparam int RUNCMD_LSB = 0;
    localparam logic [RUNCMD_W-1:0] RUNCMD_NONE = 2'd0;
    localparam logic [RUNCMD_W-1:0] RUNCMD_SYNC = 2'd1;
    localparam logic [RUNCMD_W-1:0] RUNCMD_RESET = 2'd2;
    localparam logic [RUNCMD_W-1:0] RUNCMD_STOP = 2'd3;

    // Single flag bits
    localparam int PPS_BIT = 2;
    localparam int TRIG_BIT = 3;

    // Trigger time field, bits above it are ignored
    localparam int TRIG_TIME_LSB = 4;

    //////////////////////////////////////////////////
    // Bundled types
    //////////////////////////////////////////////////

    // One-cycle run control pulses
    typedef struct packed {
        logic sync;
        logic reset;
        logic stop;
        logic pps;
    } run_ctl_t;

    // One queued trigger
    typedef struct packed {
        logic [TRIG_SEQ_W-1:0]  seq;
        logic [TRIG_TIME_W-1:0] trig_time;
    } trig_entry_t;

endpackage

`default_nettype wire
